// File: Makefile
SOURCES := build.f $(wildcard include/*.svh source/*.sv tests/*.sv)

.PHONY: all run clean

all: obj_dir/VbuzzerTb

obj_dir/VbuzzerTb: $(SOURCES)
	verilator --binary --assert -Wno-fatal --top-module buzzerTb -f build.f

run: obj_dir/VbuzzerTb
	obj_dir/VbuzzerTb | tee sim.log
	@if grep -q '\*\* FAIL \*\*' sim.log || ! grep -q '\*\* PASS \*\*' sim.log; then \
		echo "Simulation failed"; \
		exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir sim.log

// File: build.f
+incdir+include
source/buzzerPkg.sv
source/busIfs.sv
source/hostBridge.sv
source/busArbiter.sv
source/sampleRam.sv
source/playbackDma.sv
source/pwmTone.sv
source/BuzzerSubsystem.sv
tests/buzzer_properties.sv
tests/buzzerTb.sv

// File: include/buzzer_cfg.svh
`ifndef BUZZER_CFG_SVH
`define BUZZER_CFG_SVH

// ----------------------------------------------------------
// Bus and memory widths
// ----------------------------------------------------------
`define BUZ_DATA_W      32
`define BUZ_HOST_ADR_W  10
`define BUZ_RAM_ADR_W   8
`define BUZ_RAM_DEPTH   256

// Host address bit 9 set selects the register block
`define BUZ_REG_SEL_BIT 9

// Register offsets in the low two host address bits
`define BUZ_REG_START   2'd0
`define BUZ_REG_LEN     2'd1
`define BUZ_REG_CTRL    2'd2

// Sample format and playback rate
`define BUZ_SAMPLE_W    8
`define BUZ_PWM_PERIOD  256

`endif

// File: source/BuzzerSubsystem.sv
`timescale 1ns/1ns

module BuzzerSubsystem (
    input  logic                 clk,
    input  logic                 RSTn,
    input  logic                 hostCyc,
    input  logic                 hostStb,
    input  logic                 hostWe,
    input  buzzerPkg::hostAdr_t  hostAdr,
    input  buzzerPkg::data_t     hostDatW,
    output buzzerPkg::data_t     hostDatR,
    output logic                 hostAck,
    output logic                 pwm
);

    wbBus    hostBus ();
    wbBus    dmaBus ();
    wbBus    ramBus ();
    playCtrl ctrl ();

    buzzerPkg::sample_t  sample;
    logic                sampleValid;
    logic                sampleReady;

    // ----------------------------------------------------------
    // Masters of the sample RAM
    // ----------------------------------------------------------
    hostBridge uHostBridge (
        .clk      (clk),
        .RSTn     (RSTn),
        .hostCyc  (hostCyc),
        .hostStb  (hostStb),
        .hostWe   (hostWe),
        .hostAdr  (hostAdr),
        .hostDatW (hostDatW),
        .hostDatR (hostDatR),
        .hostAck  (hostAck),
        .ram      (hostBus),
        .ctrl     (ctrl)
    );

    playbackDma uPlaybackDma (
        .clk         (clk),
        .RSTn        (RSTn),
        .ctrl        (ctrl),
        .mem         (dmaBus),
        .sample      (sample),
        .sampleValid (sampleValid),
        .sampleReady (sampleReady)
    );

    // ----------------------------------------------------------
    // Shared RAM behind the arbiter
    // ----------------------------------------------------------
    busArbiter uBusArbiter (
        .clk   (clk),
        .RSTn  (RSTn),
        .hostM (hostBus),
        .dmaM  (dmaBus),
        .ram   (ramBus)
    );

    sampleRam uSampleRam (
        .clk  (clk),
        .RSTn (RSTn),
        .bus  (ramBus)
    );

    pwmTone uPwmTone (
        .clk         (clk),
        .RSTn        (RSTn),
        .sample      (sample),
        .sampleValid (sampleValid),
        .sampleReady (sampleReady),
        .pwm         (pwm)
    );

endmodule

// File: source/busArbiter.sv
`timescale 1ns/1ns

module busArbiter (
    input  logic  clk,
    input  logic  RSTn,
    wbBus.slave   hostM,
    wbBus.slave   dmaM,
    wbBus.master  ram
);

    // Grant register, set means the DMA owns the RAM
    logic ownerDma;
    logic locked;
    // Winner of the last completed cycle
    logic lastDma;
    logic holding;
    logic selDma;

    // Grant held as long as the owner keeps cyc up
    assign holding = locked && (ownerDma ? dmaM.cyc : hostM.cyc);

    always_comb begin
        if (holding) begin
            selDma = ownerDma;
        end else if (hostM.cyc && dmaM.cyc) begin
            // Both asking, the one that lost last time wins
            selDma = !lastDma;
        end else begin
            selDma = dmaM.cyc;
        end
    end

    // ----------------------------------------------------------
    // Request routing and return steering
    // ----------------------------------------------------------
    assign ram.cyc  = selDma ? dmaM.cyc  : hostM.cyc;
    assign ram.stb  = selDma ? dmaM.stb  : hostM.stb;
    assign ram.we   = selDma ? dmaM.we   : hostM.we;
    assign ram.adr  = selDma ? dmaM.adr  : hostM.adr;
    assign ram.datW = selDma ? dmaM.datW : hostM.datW;

    assign hostM.ack  = ram.ack && !selDma;
    assign dmaM.ack   = ram.ack && selDma;
    assign hostM.datR = selDma ? '0 : ram.datR;
    assign dmaM.datR  = selDma ? ram.datR : '0;

    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            locked   <= 1'b0;
            ownerDma <= 1'b0;
            lastDma  <= 1'b0;
        end else begin
            locked   <= ram.cyc;
            ownerDma <= selDma;
            if (ram.ack) begin
                lastDma <= selDma;
            end
        end
    end

endmodule

// File: source/busIfs.sv
`timescale 1ns/1ns

// ----------------------------------------------------------
// Wishbone classic, one word per cycle
// ----------------------------------------------------------
interface wbBus;
    logic                cyc;
    logic                stb;
    logic                we;
    buzzerPkg::ramAdr_t  adr;
    buzzerPkg::data_t    datW;
    buzzerPkg::data_t    datR;
    logic                ack;

    modport master (
        output cyc,
        output stb,
        output we,
        output adr,
        output datW,
        input  datR,
        input  ack
    );

    modport slave (
        input  cyc,
        input  stb,
        input  we,
        input  adr,
        input  datW,
        output datR,
        output ack
    );
endinterface

// ----------------------------------------------------------
// Playback control from the register block to the DMA
// ----------------------------------------------------------
interface playCtrl;
    buzzerPkg::ramAdr_t  startAdr;
    buzzerPkg::ramAdr_t  length;
    logic                go;
    logic                busy;

    modport source (output startAdr, output length, output go, input busy);
    modport sink (input startAdr, input length, input go, output busy);
endinterface

// File: source/buzzerPkg.sv
`include "buzzer_cfg.svh"

package buzzerPkg;

    // One bus or RAM data word
    typedef logic [`BUZ_DATA_W-1:0] data_t;

    // Word address as seen by the host
    typedef logic [`BUZ_HOST_ADR_W-1:0] hostAdr_t;

    // Word address inside the sample RAM, also a word count
    typedef logic [`BUZ_RAM_ADR_W-1:0] ramAdr_t;

    // PWM duty value of one sample
    typedef logic [`BUZ_SAMPLE_W-1:0] sample_t;

    // Playback DMA states
    typedef enum logic [1:0] {
        dmaIdle,
        dmaFetch,
        dmaUnpack
    } dmaState_t;

endpackage

// File: source/hostBridge.sv
`timescale 1ns/1ns
`include "buzzer_cfg.svh"

module hostBridge (
    input  logic                 clk,
    input  logic                 RSTn,
    input  logic                 hostCyc,
    input  logic                 hostStb,
    input  logic                 hostWe,
    input  buzzerPkg::hostAdr_t  hostAdr,
    input  buzzerPkg::data_t     hostDatW,
    output buzzerPkg::data_t     hostDatR,
    output logic                 hostAck,
    wbBus.master                 ram,
    playCtrl.source              ctrl
);

    logic                regSel;
    logic [1:0]          regOff;
    logic                regAccess;
    logic                regAck;
    buzzerPkg::data_t    regDat;
    buzzerPkg::ramAdr_t  startReg;
    buzzerPkg::ramAdr_t  lenReg;
    logic                goReg;

    assign regSel    = hostAdr[`BUZ_REG_SEL_BIT];
    assign regOff    = hostAdr[1:0];
    assign regAccess = hostCyc && hostStb && regSel && !regAck;

    // RAM cycles go straight to the arbiter
    assign ram.cyc  = hostCyc && !regSel;
    assign ram.stb  = hostStb && !regSel;
    assign ram.we   = hostWe;
    assign ram.adr  = hostAdr[`BUZ_RAM_ADR_W-1:0];
    assign ram.datW = hostDatW;

    assign hostAck  = regAck || ram.ack;
    assign hostDatR = regAck ? regDat : ram.datR;

    assign ctrl.startAdr = startReg;
    assign ctrl.length   = lenReg;
    assign ctrl.go       = goReg;

    // ----------------------------------------------------------
    // Register block, one clock to ack
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            regAck   <= 1'b0;
            goReg    <= 1'b0;
            startReg <= '0;
            lenReg   <= '0;
        end else begin
            regAck <= regAccess;
            // Start bit in the control register gives a single go pulse
            goReg  <= regAccess && hostWe && (regOff == `BUZ_REG_CTRL) && hostDatW[0];
            if (regAccess && hostWe && regOff == `BUZ_REG_START) begin
                startReg <= hostDatW[`BUZ_RAM_ADR_W-1:0];
            end
            if (regAccess && hostWe && regOff == `BUZ_REG_LEN) begin
                lenReg <= hostDatW[`BUZ_RAM_ADR_W-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (regAccess) begin
            if (regOff == `BUZ_REG_START) begin
                regDat <= buzzerPkg::data_t'(startReg);
            end else if (regOff == `BUZ_REG_LEN) begin
                regDat <= buzzerPkg::data_t'(lenReg);
            end else if (regOff == `BUZ_REG_CTRL) begin
                regDat <= buzzerPkg::data_t'(ctrl.busy);
            end else begin
                regDat <= '0;
            end
        end
    end

endmodule

// File: source/playbackDma.sv
`timescale 1ns/1ns
`include "buzzer_cfg.svh"

module playbackDma (
    input  logic                clk,
    input  logic                RSTn,
    playCtrl.sink               ctrl,
    wbBus.master                mem,
    output buzzerPkg::sample_t  sample,
    output logic                sampleValid,
    input  logic                sampleReady
);

    buzzerPkg::dmaState_t  state;
    buzzerPkg::ramAdr_t    curAdr;
    // Words still to fetch after the one in hand
    buzzerPkg::ramAdr_t    wordsLeft;
    buzzerPkg::data_t      word;
    logic [1:0]            byteIdx;
    logic                  take;

    assign take        = sampleValid && sampleReady;
    assign sampleValid = (state == buzzerPkg::dmaUnpack);
    // Low byte first, the word shifts down after each hand-off
    assign sample      = buzzerPkg::sample_t'(word);
    assign ctrl.busy   = (state != buzzerPkg::dmaIdle);

    // Read-only master
    assign mem.cyc  = (state == buzzerPkg::dmaFetch);
    assign mem.stb  = (state == buzzerPkg::dmaFetch);
    assign mem.we   = 1'b0;
    assign mem.adr  = curAdr;
    assign mem.datW = '0;

    // ----------------------------------------------------------
    // Fetch and unpack FSM
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            state     <= buzzerPkg::dmaIdle;
            curAdr    <= '0;
            wordsLeft <= '0;
            byteIdx   <= '0;
        end else begin
            case (state)
                buzzerPkg::dmaIdle: begin
                    // go while busy never reaches here
                    if (ctrl.go && ctrl.length != '0) begin
                        curAdr    <= ctrl.startAdr;
                        wordsLeft <= ctrl.length;
                        state     <= buzzerPkg::dmaFetch;
                    end
                end
                buzzerPkg::dmaFetch: begin
                    if (mem.ack) begin
                        curAdr    <= curAdr + 1'b1;
                        wordsLeft <= wordsLeft - 1'b1;
                        byteIdx   <= '0;
                        state     <= buzzerPkg::dmaUnpack;
                    end
                end
                buzzerPkg::dmaUnpack: begin
                    if (take) begin
                        byteIdx <= byteIdx + 1'b1;
                        // Next word goes out while the tone generator plays
                        if (byteIdx == 2'd3) begin
                            state <= (wordsLeft == '0) ? buzzerPkg::dmaIdle
                                                       : buzzerPkg::dmaFetch;
                        end
                    end
                end
                default: state <= buzzerPkg::dmaIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == buzzerPkg::dmaFetch && mem.ack) begin
            word <= mem.datR;
        end else if (take) begin
            word <= word >> `BUZ_SAMPLE_W;
        end
    end

endmodule

// File: source/pwmTone.sv
`timescale 1ns/1ns
`include "buzzer_cfg.svh"

module pwmTone (
    input  logic                clk,
    input  logic                RSTn,
    input  buzzerPkg::sample_t  sample,
    input  logic                sampleValid,
    output logic                sampleReady,
    output logic                pwm
);

    buzzerPkg::sample_t  bufData;
    logic                bufValid;
    buzzerPkg::sample_t  duty;
    buzzerPkg::sample_t  cnt;
    logic                running;
    logic                take;
    logic                periodEnd;
    logic                newPeriod;

    assign sampleReady = !bufValid;
    assign take        = sampleValid && sampleReady;
    assign periodEnd   = running && (cnt == buzzerPkg::sample_t'(`BUZ_PWM_PERIOD - 1));
    // Buffered sample first, else one arriving right now
    assign newPeriod   = (!running || periodEnd) && (bufValid || take);
    assign pwm         = running && (cnt < duty);

    // ----------------------------------------------------------
    // Period counter and one-entry buffer
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            running  <= 1'b0;
            cnt      <= '0;
            bufValid <= 1'b0;
        end else if (newPeriod) begin
            running  <= 1'b1;
            cnt      <= '0;
            bufValid <= 1'b0;
        end else if (periodEnd || !running) begin
            running <= 1'b0;
        end else begin
            cnt <= cnt + 1'b1;
            if (take) begin
                bufValid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (newPeriod) begin
            duty <= bufValid ? bufData : sample;
        end
        if (take && !newPeriod) begin
            bufData <= sample;
        end
    end

endmodule

// File: source/sampleRam.sv
`timescale 1ns/1ns
`include "buzzer_cfg.svh"

module sampleRam (
    input  logic  clk,
    input  logic  RSTn,
    wbBus.slave   bus
);

    buzzerPkg::data_t words [`BUZ_RAM_DEPTH];
    logic             access;

    // ----------------------------------------------------------
    // One access per strobe, acked on the next clock
    // ----------------------------------------------------------

    // No second access while the ack of the first is out
    assign access = bus.cyc && bus.stb && !bus.ack;

    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= access;
        end
    end

    // Write lands on the edge that raises ack
    always_ff @(posedge clk) begin
        if (access && bus.we) begin
            words[bus.adr] <= bus.datW;
        end
    end

    // Read data registered, valid together with ack
    always_ff @(posedge clk) begin
        if (access) begin
            bus.datR <= words[bus.adr];
        end
    end

endmodule

// File: tests/buzzerTb.sv
`timescale 1ns/1ns
`include "buzzer_cfg.svh"

module buzzerTb;

    localparam int clkPeriod = 100;
    localparam int firstStart = 0;
    localparam int firstWords = 3;
    localparam int secondStart = 16;
    localparam int secondWords = 4;
    localparam int sharedReads = 40;
    // All pulses of both playbacks plus room for every host access
    localparam int playClocks = 4 * (firstWords + secondWords) * `BUZ_PWM_PERIOD;
    localparam int hostAccesses = 100;
    localparam int accessMargin = 64;
    localparam longint timeLimit =
        longint'(playClocks + hostAccesses * accessMargin + 100) * clkPeriod;

    logic                 clk;
    logic                 RSTn;
    logic                 hostCyc;
    logic                 hostStb;
    logic                 hostWe;
    buzzerPkg::hostAdr_t  hostAdr;
    buzzerPkg::data_t     hostDatW;
    buzzerPkg::data_t     hostDatR;
    logic                 hostAck;
    logic                 pwm;

    logic [31:0]          lfsr;
    buzzerPkg::data_t     shadow [`BUZ_RAM_DEPTH];
    int                   pulseWidths [$];
    int                   pulseStarts [$];
    int                   highCount;
    int                   clkIndex;
    logic                 pwmPrev;
    int                   checks;
    int                   errors;
    int                   errorsBefore;
    int                   tests;

    BuzzerSubsystem DUT (
        .clk      (clk),
        .RSTn     (RSTn),
        .hostCyc  (hostCyc),
        .hostStb  (hostStb),
        .hostWe   (hostWe),
        .hostAdr  (hostAdr),
        .hostDatW (hostDatW),
        .hostDatR (hostDatR),
        .hostAck  (hostAck),
        .pwm      (pwm)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    initial begin
        #(timeLimit);
        $display("Watchdog expired before all tests finished");
        $display("** FAIL **");
        $finish;
    end

    // Pulse meter, pwm only moves on the rising edge
    always @(negedge clk) begin
        clkIndex = clkIndex + 1;
        if (pwm && !pwmPrev) begin
            pulseStarts.push_back(clkIndex);
        end
        if (pwm) begin
            highCount = highCount + 1;
        end else if (highCount != 0) begin
            pulseWidths.push_back(highCount);
            highCount = 0;
        end
        pwmPrev = pwm;
    end

    // ----------------------------------------------------------
    // Random data
    // ----------------------------------------------------------

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One step per bit, zero bytes bumped to 1 so every pulse shows
    function automatic buzzerPkg::data_t randomSamples();
        buzzerPkg::data_t w;
        for (int b = 0; b < 32; b++) begin
            lfsr = lfsrNext(lfsr);
            w[b] = lfsr[0];
        end
        for (int k = 0; k < 4; k++) begin
            if (w[8*k +: 8] == 8'h00) begin
                w[8*k +: 8] = 8'h01;
            end
        end
        return w;
    endfunction

    // ----------------------------------------------------------
    // Host bus and checks
    // ----------------------------------------------------------
    function automatic buzzerPkg::hostAdr_t regAdr(input logic [1:0] off);
        regAdr = '0;
        regAdr[`BUZ_REG_SEL_BIT] = 1'b1;
        regAdr[1:0] = off;
    endfunction

    task automatic hostAccess(input logic we, input buzzerPkg::hostAdr_t adr,
                              input buzzerPkg::data_t datW, output buzzerPkg::data_t datR);
        @(negedge clk);
        hostCyc  = 1'b1;
        hostStb  = 1'b1;
        hostWe   = we;
        hostAdr  = adr;
        hostDatW = datW;
        @(negedge clk);
        while (!hostAck) begin
            @(negedge clk);
        end
        datR = hostDatR;
        // Request stays up through the clock after ack
        @(negedge clk);
        hostCyc = 1'b0;
        hostStb = 1'b0;
        hostWe  = 1'b0;
    endtask

    task automatic hostWrite(input buzzerPkg::hostAdr_t adr, input buzzerPkg::data_t dat);
        buzzerPkg::data_t unused;
        hostAccess(1'b1, adr, dat, unused);
    endtask

    task automatic hostRead(input buzzerPkg::hostAdr_t adr, output buzzerPkg::data_t dat);
        hostAccess(1'b0, adr, '0, dat);
    endtask

    function automatic void expectEqual(input string what, input logic [31:0] got,
                                        input logic [31:0] exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endfunction

    task automatic finishTest(input string name);
        tests++;
        $display("Test %0d (%s) finished with %0d errors", tests, name, errors - errorsBefore);
        errorsBefore = errors;
    endtask

    task automatic startPlayback(input int start, input int words);
        hostWrite(regAdr(`BUZ_REG_START), buzzerPkg::data_t'(start));
        hostWrite(regAdr(`BUZ_REG_LEN), buzzerPkg::data_t'(words));
        pulseWidths.delete();
        pulseStarts.delete();
        hostWrite(regAdr(`BUZ_REG_CTRL), 32'h1);
    endtask

    // Widths follow the bytes low first, one period apart
    task automatic checkPulses(input int start, input int words);
        int n;
        n = 4 * words;
        while (pulseWidths.size() < n) begin
            @(negedge clk);
        end
        for (int i = 0; i < n; i++) begin
            expectEqual("pulse width", pulseWidths[i], shadow[start + i / 4][8*(i % 4) +: 8]);
            if (i > 0) begin
                expectEqual("pulse spacing", pulseStarts[i] - pulseStarts[i-1],
                            `BUZ_PWM_PERIOD);
            end
        end
    endtask

    // ----------------------------------------------------------
    // Tests
    // ----------------------------------------------------------
    initial begin
        buzzerPkg::data_t rd;
        int idx;
        RSTn     = 1'b0;
        hostCyc  = 1'b0;
        hostStb  = 1'b0;
        hostWe   = 1'b0;
        hostAdr  = '0;
        hostDatW = '0;
        lfsr     = 32'hf1b2017d;
        clkIndex = 0;
        highCount = 0;
        pwmPrev  = 1'b0;
        checks   = 0;
        errors   = 0;
        errorsBefore = 0;
        tests    = 0;
        repeat (10) @(negedge clk);
        RSTn = 1'b1;

        expectEqual("hostAck after reset", hostAck, 0);
        expectEqual("pwm after reset", pwm, 0);
        hostRead(regAdr(`BUZ_REG_CTRL), rd);
        expectEqual("busy after reset", rd[0], 0);
        finishTest("reset");

        for (int i = 0; i < firstWords + secondWords; i++) begin
            idx = (i < firstWords) ? firstStart + i : secondStart + i - firstWords;
            shadow[idx] = randomSamples();
            hostWrite(buzzerPkg::hostAdr_t'(idx), shadow[idx]);
        end
        for (int i = 0; i < firstWords + secondWords; i++) begin
            idx = (i < firstWords) ? firstStart + i : secondStart + i - firstWords;
            hostRead(buzzerPkg::hostAdr_t'(idx), rd);
            expectEqual("RAM readback", rd, shadow[idx]);
        end
        hostWrite(regAdr(`BUZ_REG_START), 32'd37);
        hostWrite(regAdr(`BUZ_REG_LEN), 32'd5);
        hostRead(regAdr(`BUZ_REG_START), rd);
        expectEqual("start register", rd, 37);
        hostRead(regAdr(`BUZ_REG_LEN), rd);
        expectEqual("length register", rd, 5);
        finishTest("RAM and registers");

        startPlayback(firstStart, firstWords);
        hostRead(regAdr(`BUZ_REG_CTRL), rd);
        expectEqual("busy during playback", rd[0], 1);
        checkPulses(firstStart, firstWords);
        hostRead(regAdr(`BUZ_REG_CTRL), rd);
        expectEqual("busy after playback", rd[0], 0);
        finishTest("playback");

        // Second start aimed at other words, must be ignored
        startPlayback(secondStart, secondWords);
        hostWrite(regAdr(`BUZ_REG_START), buzzerPkg::data_t'(firstStart));
        hostWrite(regAdr(`BUZ_REG_CTRL), 32'h1);
        for (int i = 0; i < sharedReads; i++) begin
            idx = (i % 2 == 1) ? firstStart + (i / 2) % firstWords
                               : secondStart + (i / 2) % secondWords;
            hostRead(buzzerPkg::hostAdr_t'(idx), rd);
            expectEqual("RAM read during playback", rd, shadow[idx]);
            repeat (50) @(negedge clk);
        end
        checkPulses(secondStart, secondWords);
        hostRead(regAdr(`BUZ_REG_CTRL), rd);
        expectEqual("busy after second playback", rd[0], 0);
        finishTest("restart and shared RAM");

        // Failed bound properties count as errors too
        errors = errors + DUT.uProperties.failCount;
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: tests/buzzer_properties.sv
`timescale 1ns/1ns

module buzzerProperties (
    input logic clk,
    input logic RSTn,
    input logic hostCyc,
    input logic hostStb,
    input logic hostAck,
    input logic pwm,
    input logic busy,
    input logic running,
    input logic hostSideCyc,
    input logic hostSideAck,
    input logic dmaSideCyc,
    input logic dmaSideAck
);

    // Number of failed properties
    int failCount = 0;

    // ----------------------------------------------------------
    // Host port handshake
    // ----------------------------------------------------------
    assert property (@(posedge clk) disable iff (!RSTn)
        $rose(hostAck) |-> hostCyc && hostStb)
        else begin
            $error("hostAck rose outside a host bus cycle");
            failCount++;
        end

    assert property (@(posedge clk) disable iff (!RSTn)
        hostAck |=> !hostAck)
        else begin
            $error("hostAck stayed high longer than one clock");
            failCount++;
        end

    // Silent output when nothing plays and no sample can arrive
    assert property (@(posedge clk) disable iff (!RSTn)
        !busy && !running |=> !pwm)
        else begin
            $error("pwm high with the DMA idle and no period running");
            failCount++;
        end

    // Arbiter returns each ack only to the master that owns the cycle
    assert property (@(posedge clk) disable iff (!RSTn)
        (!hostSideAck || hostSideCyc) && (!dmaSideAck || dmaSideCyc))
        else begin
            $error("ack given to a bus master without an open cycle");
            failCount++;
        end

endmodule

bind BuzzerSubsystem buzzerProperties uProperties (
    .clk         (clk),
    .RSTn        (RSTn),
    .hostCyc     (hostCyc),
    .hostStb     (hostStb),
    .hostAck     (hostAck),
    .pwm         (pwm),
    .busy        (ctrl.busy),
    .running     (uPwmTone.running),
    .hostSideCyc (hostBus.cyc),
    .hostSideAck (hostBus.ack),
    .dmaSideCyc  (dmaBus.cyc),
    .dmaSideAck  (dmaBus.ack)
);
